// ==== rtl/fdiv_fmt_pkg.sv ====
// Single-precision format definitions for the floating-point divider.
// Holds the IEEE field widths, the operand and result types and the
// special-case flag set that goes to the rounder.
`default_nettype none

package fdiv_fmt_pkg;

    localparam int EXP_BIAS = 127;
    localparam int EXP_W    = 8;
    localparam int MANT_W   = 23;

    // raw operand, sign then exponent then fraction
    typedef logic [EXP_W+MANT_W:0] float_t;

    // two extra bits keep results below zero or above 254 visible
    typedef logic signed [EXP_W+1:0] exp_t;

    // significand including the hidden bit
    typedef logic [MANT_W:0] mant_t;

    // guard, round, sticky
    typedef logic [2:0] grs_t;

    typedef struct packed {
        logic snan;
        logic qnan;
        logic dbz;
        logic infs;
        logic zero;
    } div_flags_t;

    // handed to the external rounder
    typedef struct packed {
        logic       sign;
        exp_t       exp;
        mant_t      mant;
        grs_t       grs;
        div_flags_t flags;
    } div_result_t;

endpackage

`default_nettype wire

// ==== rtl/fdiv_calc_pkg.sv ====
// Working-arithmetic definitions for the pipelined divider.
// Fixed-point reciprocal and quotient widths, seed table size,
// refinement count and the record carried from stage to stage.
`default_nettype none

package fdiv_calc_pkg;

    import fdiv_fmt_pkg::*;

    // reciprocal has 2 integer and 32 fraction bits
    localparam int RECIP_W      = 34;
    localparam int RECIP_FRAC_W = 32;
    typedef logic [RECIP_W-1:0] recip_t;

    // seed table indexed by the top divisor fraction bits
    localparam int SEED_IDX_W = 7;
    localparam int SEED_N     = 2 ** SEED_IDX_W;
    localparam int SEED_W     = 8;

    localparam int NR_ITERS = 2;

    // quotient with 26 fraction bits
    localparam int QUO_W = 27;
    typedef logic [QUO_W-1:0] quo_t;

    // seed + refinements + finish
    localparam int LATENCY = NR_ITERS + 2;

    typedef struct packed {
        logic       valid;
        logic       sign;
        exp_t       exp;
        mant_t      mant_a;
        mant_t      mant_b;
        recip_t     recip;
        div_flags_t flags;
    } div_stage_t;

endpackage

`default_nettype wire

// ==== rtl/fdiv_seed.sv ====
// Divider seed stage.
// Classifies both operands and raises the special-case flags, forms the
// result sign and rebiased exponent, and looks up an 8-bit reciprocal
// estimate of the divisor significand. One register stage.
`timescale 1ns/1ps
`default_nettype none

module fdiv_seed
    import fdiv_fmt_pkg::*;
    import fdiv_calc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid_i,
    input  float_t     a_i,
    input  float_t     b_i,
    output div_stage_t stage_o
);

    typedef struct packed {
        logic zero;
        logic inf;
        logic qnan;
        logic snan;
    } op_class_t;

    typedef logic [SEED_N-1:0][SEED_W-1:0] seed_table_t;

    // entry i is 1/midpoint of [1 + i/N, 1 + (i+1)/N), rounded
    function automatic seed_table_t build_seed_table();
        seed_table_t tbl;
        int          den;
        for (int i = 0; i < SEED_N; i++) begin
            den    = 2 ** (SEED_IDX_W + 1) + 2 * i + 1;
            tbl[i] = SEED_W'((2 ** (SEED_W + SEED_IDX_W + 2) + den) / (2 * den));
        end
        return tbl;
    endfunction

    localparam seed_table_t SEED_TABLE = build_seed_table();

    function automatic op_class_t classify(float_t x);
        logic [EXP_W-1:0]  e;
        logic [MANT_W-1:0] f;
        op_class_t         c;
        e      = x[MANT_W +: EXP_W];
        f      = x[MANT_W-1:0];
        // no subnormal support, a zero exponent counts as zero
        c.zero = (e == '0);
        c.inf  = (e == '1) && (f == '0);
        c.qnan = (e == '1) && f[MANT_W-1];
        c.snan = (e == '1) && !f[MANT_W-1] && (f != '0);
        return c;
    endfunction

    op_class_t             cls_a;
    op_class_t             cls_b;
    logic                  a_fin_nz;
    logic                  b_fin;
    logic                  invalid;
    logic [SEED_IDX_W-1:0] seed_idx;
    div_stage_t            st_d;

    always_comb begin
        cls_a    = classify(a_i);
        cls_b    = classify(b_i);
        a_fin_nz = !(cls_a.zero | cls_a.inf | cls_a.qnan | cls_a.snan);
        b_fin    = !(cls_b.inf | cls_b.qnan | cls_b.snan);

        // 0/0 and inf/inf are invalid like a signalling input
        invalid = cls_a.snan | cls_b.snan | (cls_a.zero & cls_b.zero)
                | (cls_a.inf & cls_b.inf);

        st_d.flags.snan = invalid;
        st_d.flags.qnan = !invalid & (cls_a.qnan | cls_b.qnan);
        st_d.flags.dbz  = a_fin_nz & cls_b.zero;
        st_d.flags.infs = cls_a.inf & b_fin;
        st_d.flags.zero = cls_a.zero | cls_b.inf;

        st_d.valid  = in_valid_i;
        st_d.sign   = a_i[EXP_W+MANT_W] ^ b_i[EXP_W+MANT_W];
        st_d.exp    = exp_t'(a_i[MANT_W +: EXP_W]) - exp_t'(b_i[MANT_W +: EXP_W])
                    + exp_t'(EXP_BIAS);
        st_d.mant_a = {1'b1, a_i[MANT_W-1:0]};
        st_d.mant_b = {1'b1, b_i[MANT_W-1:0]};

        // table value sits just below the binary point
        seed_idx   = b_i[MANT_W-1 -: SEED_IDX_W];
        st_d.recip = recip_t'(SEED_TABLE[seed_idx]) << (RECIP_FRAC_W - SEED_W);
    end

    always_ff @(posedge clk) begin
        stage_o <= st_d;
        if (!rst_n) begin
            stage_o.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fdiv_nr_stage.sv ====
// One Newton-Raphson refinement of the divisor reciprocal.
// Computes e = 1 - b*y and y' = y + y*e, roughly doubling the number
// of correct bits. All other fields of the stage record pass through.
`timescale 1ns/1ps
`default_nettype none

module fdiv_nr_stage
    import fdiv_fmt_pkg::*;
    import fdiv_calc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  div_stage_t stage_i,
    output div_stage_t stage_o
);

    // b*y product, 23 + 32 fraction bits
    localparam int BY_W    = MANT_W + 1 + RECIP_W;
    localparam int BY_FRAC = MANT_W + RECIP_FRAC_W;
    localparam logic [BY_W-1:0] ONE_FX = BY_W'(1) << BY_FRAC;

    logic [BY_W-1:0]           by_prod;
    logic signed [BY_W:0]      err_full;
    logic signed [RECIP_W-1:0] err;
    logic signed [2*RECIP_W:0] ye_prod;
    recip_t                    y_next;
    div_stage_t                st_d;

    always_comb begin
        by_prod  = stage_i.mant_b * stage_i.recip;
        err_full = $signed({1'b0, ONE_FX}) - $signed({1'b0, by_prod});
        // keep 32 fraction bits of the error
        err      = err_full[MANT_W +: RECIP_W];

        ye_prod = $signed({1'b0, stage_i.recip}) * err;
        // truncated correction keeps y at or just under 1/b
        y_next  = stage_i.recip + recip_t'(ye_prod[RECIP_FRAC_W +: RECIP_W]);

        st_d       = stage_i;
        st_d.recip = y_next;
    end

    always_ff @(posedge clk) begin
        stage_o <= st_d;
        if (!rst_n) begin
            stage_o.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fdiv_finish.sv ====
// Divider finishing stage.
// Multiplies the dividend by the refined reciprocal, corrects the
// estimate to the exact truncated quotient with a remainder check,
// normalizes, denormalizes on underflow and extracts guard, round and
// sticky for the rounder.
`timescale 1ns/1ps
`default_nettype none

module fdiv_finish
    import fdiv_fmt_pkg::*;
    import fdiv_calc_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  div_stage_t  stage_i,
    output logic        out_valid_o,
    output div_result_t result_o
);

    localparam int PROD_W    = QUO_W + RECIP_W;
    localparam int REM_W     = QUO_W + MANT_W + 2;
    localparam int SH_W      = $clog2(QUO_W);
    localparam int GRS_SHIFT = QUO_W - MANT_W - 1;

    quo_t                    dvd_fx;
    logic [PROD_W-1:0]       q_prod;
    quo_t                    q_est;
    quo_t                    q_sel;
    quo_t                    q_norm;
    quo_t                    q_den;
    logic signed [REM_W-1:0] dvd_full;
    logic signed [REM_W-1:0] dvs_full;
    logic signed [REM_W-1:0] q_est_s;
    logic signed [REM_W-1:0] rem_mid;
    logic signed [REM_W-1:0] rem_lo;
    logic signed [REM_W-1:0] rem_hi;
    logic signed [REM_W-1:0] rem_sel;
    exp_t                    exp_norm;
    exp_t                    dn_amt;
    logic [SH_W-1:0]         dn_shift;
    logic                    underflow;
    logic                    lost;
    logic                    rem_nz;
    div_result_t             res_d;

    always_comb begin
        // dividend with 3 low positions, quotient gets 26 fraction bits
        dvd_fx = quo_t'(stage_i.mant_a) << GRS_SHIFT;
        q_prod = dvd_fx * stage_i.recip;
        q_est  = q_prod[RECIP_FRAC_W +: QUO_W];

        // remainders a*2^26 - q*b for q, q-1 and q+1
        dvd_full = REM_W'(dvd_fx) << MANT_W;
        dvs_full = REM_W'(stage_i.mant_b);
        q_est_s  = REM_W'(q_est);
        rem_mid  = dvd_full - q_est_s * dvs_full;
        rem_lo   = rem_mid + dvs_full;
        rem_hi   = rem_mid - dvs_full;

        // pick the candidate with 0 <= r < b
        if (rem_mid < 0) begin
            q_sel   = q_est - quo_t'(1);
            rem_sel = rem_lo;
        end else if (rem_hi >= 0) begin
            q_sel   = q_est + quo_t'(1);
            rem_sel = rem_hi;
        end else begin
            q_sel   = q_est;
            rem_sel = rem_mid;
        end

        // a < b leaves the top bit clear
        if (q_sel[QUO_W-1]) begin
            q_norm   = q_sel;
            exp_norm = stage_i.exp;
        end else begin
            q_norm   = q_sel << 1;
            exp_norm = stage_i.exp - exp_t'(1);
        end

        // underflow shift, 1 - exp, at most 26
        underflow = (exp_norm <= exp_t'(0));
        dn_amt    = exp_t'(1) - exp_norm;
        if (!underflow) begin
            dn_shift = '0;
        end else if (dn_amt > exp_t'(QUO_W - 1)) begin
            dn_shift = SH_W'(QUO_W - 1);
        end else begin
            dn_shift = dn_amt[SH_W-1:0];
        end

        q_den  = q_norm >> dn_shift;
        lost   = |(q_norm & ~({QUO_W{1'b1}} << dn_shift));
        rem_nz = (rem_sel != '0);

        res_d.sign  = stage_i.sign;
        res_d.exp   = underflow ? exp_t'(0) : exp_norm;
        res_d.mant  = q_den[QUO_W-1 -: MANT_W+1];
        res_d.grs   = {q_den[GRS_SHIFT-1 -: 2], q_den[0] | lost | rem_nz};
        res_d.flags = stage_i.flags;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= stage_i.valid;
        end
        result_o <= res_d;
    end

endmodule

`default_nettype wire

// ==== rtl/fdiv_top.sv ====
// Pipelined single-precision divider.
// Seed lookup, NR_ITERS Newton-Raphson reciprocal refinements and a
// finishing stage, one register each. Accepts a new operand pair on
// every clock and returns the unrounded result LATENCY cycles later.
`timescale 1ns/1ps
`default_nettype none

module fdiv_top
    import fdiv_fmt_pkg::*;
    import fdiv_calc_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid_i,
    input  float_t      a_i,
    input  float_t      b_i,
    output logic        out_valid_o,
    output div_result_t result_o
);

    // entry 0 from the seed, last entry feeds the finish
    div_stage_t stage_chain [0:NR_ITERS];

    fdiv_seed u_seed (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid_i(in_valid_i),
        .a_i       (a_i),
        .b_i       (b_i),
        .stage_o   (stage_chain[0])
    );

    for (genvar i = 0; i < NR_ITERS; i++) begin : g_nr
        fdiv_nr_stage u_nr (
            .clk    (clk),
            .rst_n  (rst_n),
            .stage_i(stage_chain[i]),
            .stage_o(stage_chain[i+1])
        );
    end

    fdiv_finish u_finish (
        .clk        (clk),
        .rst_n      (rst_n),
        .stage_i    (stage_chain[NR_ITERS]),
        .out_valid_o(out_valid_o),
        .result_o   (result_o)
    );

endmodule

`default_nettype wire

// ==== bench/fdiv_checker.sv ====
// Bound assertions for the pipelined divider.
// Fixed valid latency, a quiet output strobe during reset and
// normalized significands on unflagged results.
`timescale 1ns/1ps
`default_nettype none

module fdiv_checker
    import fdiv_fmt_pkg::*;
    import fdiv_calc_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic        in_valid_i,
    input logic        out_valid_i,
    input div_result_t result_i
);

    // strobe sampled at edge k is seen high at edge k + LATENCY
    valid_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(rst_n, LATENCY) |-> (out_valid_i == $past(in_valid_i, LATENCY))
    ) else $error("out_valid_o does not follow in_valid_i by the pipeline latency");

    reset_quiet: assert property (
        @(posedge clk) (!rst_n && !$past(rst_n)) |-> !out_valid_i
    ) else $error("out_valid_o high while reset is held");

    // hidden bit set unless the result was denormalized
    normalized: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_valid_i && result_i.flags == '0 && result_i.exp != '0) |-> result_i.mant[MANT_W]
    ) else $error("unflagged result with nonzero exponent is not normalized");

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
// Clock and reset source for the divider testbench.
// 10 ns clock, reset held low over the first two rising edges.
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 2;

    logic clk   = 1'b0;
    logic rst_n = 1'b0;

    always #(HALF_PERIOD) clk = ~clk;

    initial begin
        repeat (RESET_CYCLES) @(posedge clk);
        // release away from the sampling edge
        @(negedge clk);
        rst_n = 1'b1;
    end

    assign clk_o   = clk;
    assign rst_n_o = rst_n;

endmodule

`default_nettype wire

// ==== bench/fdiv_tb.sv ====
// Testbench for the pipelined single-precision divider.
// Random operand pairs from an LFSR with special values mixed in, driven
// on the falling edge; each result is compared with a behavioral model
// of the exact truncated quotient and its arrival time is checked.
`timescale 1ns/1ps
`default_nettype none

module fdiv_tb
    import fdiv_fmt_pkg::*;
    import fdiv_calc_pkg::*;
();

    localparam logic [31:0] LFSR_SEED  = 32'h654f_4f6e;
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
    localparam int          NUM_OPS    = 600;
    localparam int          MAX_CYCLES = 4 * NUM_OPS;
    localparam int          RESET_WAIT = 20;
    localparam int          DRAIN_WAIT = LATENCY + 8;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    float_t      op_a;
    float_t      op_b;
    logic        out_valid;
    div_result_t result;

    logic [31:0] lfsr_state;
    float_t      pend_a [$];
    float_t      pend_b [$];
    int          pend_cycle [$];
    int          issued       = 0;
    int          timeouts     = 0;
    int          cycle        = 0;
    int          checked      = 0;
    int          mismatches   = 0;
    int          other_errors = 0;
    logic        reset_seen   = 1'b0;

    tb_clock u_clock (
        .clk_o  (clk),
        .rst_n_o(rst_n)
    );

    fdiv_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid_i (in_valid),
        .a_i        (op_a),
        .b_i        (op_b),
        .out_valid_o(out_valid),
        .result_o   (result)
    );

    bind fdiv_top fdiv_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid_i (in_valid_i),
        .out_valid_i(out_valid_o),
        .result_i   (result_o)
    );

    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one LFSR step per returned bit
    function automatic logic [31:0] draw_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic float_t make_operand();
        logic              sign;
        logic [EXP_W-1:0]  e;
        logic [MANT_W-1:0] f;
        sign = 1'(draw_bits(1));
        if (3'(draw_bits(3)) == 3'd0) begin
            // zero, infinity, quiet NaN or signalling NaN
            e = '1;
            f = MANT_W'(draw_bits(MANT_W - 1));
            case (2'(draw_bits(2)))
                2'd0: begin
                    e = '0;
                    f = '0;
                end
                2'd1:    f = '0;
                2'd2:    f[MANT_W-1] = 1'b1;
                default: f[0] = 1'b1;
            endcase
        end else begin
            if (1'(draw_bits(1))) begin
                // full exponent range reaches underflow and overflow
                e = EXP_W'(draw_bits(EXP_W));
                if (e == '0) begin
                    e = EXP_W'(1);
                end else if (e == '1) begin
                    e = EXP_W'(254);
                end
            end else begin
                e = EXP_W'(EXP_BIAS - 16) + EXP_W'(draw_bits(5));
            end
            f = MANT_W'(draw_bits(MANT_W));
        end
        return {sign, e, f};
    endfunction

    function automatic div_result_t model_divide(float_t a, float_t b);
        div_result_t       r;
        logic [EXP_W-1:0]  ea;
        logic [EXP_W-1:0]  eb;
        logic [MANT_W-1:0] fa;
        logic [MANT_W-1:0] fb;
        logic              a_zero;
        logic              a_inf;
        logic              a_qnan;
        logic              a_snan;
        logic              b_zero;
        logic              b_inf;
        logic              b_qnan;
        logic              b_snan;
        logic [63:0]       num;
        logic [63:0]       den;
        logic [63:0]       quo;
        logic              rem_nz;
        logic              lost;
        int                e;
        int                sh;
        ea     = a[MANT_W +: EXP_W];
        eb     = b[MANT_W +: EXP_W];
        fa     = a[MANT_W-1:0];
        fb     = b[MANT_W-1:0];
        a_zero = (ea == '0);
        a_inf  = (ea == '1) && (fa == '0);
        a_qnan = (ea == '1) && fa[MANT_W-1];
        a_snan = (ea == '1) && !fa[MANT_W-1] && (fa != '0);
        b_zero = (eb == '0);
        b_inf  = (eb == '1) && (fb == '0);
        b_qnan = (eb == '1) && fb[MANT_W-1];
        b_snan = (eb == '1) && !fb[MANT_W-1] && (fb != '0);

        r            = '0;
        r.flags.snan = a_snan || b_snan || (a_zero && b_zero) || (a_inf && b_inf);
        r.flags.qnan = !r.flags.snan && (a_qnan || b_qnan);
        r.flags.infs = a_inf && !(b_inf || b_qnan || b_snan);
        r.flags.dbz  = !(a_zero || a_inf || a_qnan || a_snan) && b_zero;
        r.flags.zero = a_zero || b_inf;
        r.sign       = a[EXP_W+MANT_W] ^ b[EXP_W+MANT_W];

        // 26 fraction bits of the exact quotient
        num    = 64'({1'b1, fa}) << (QUO_W - 1);
        den    = 64'({1'b1, fb});
        quo    = num / den;
        rem_nz = ((num % den) != 64'd0);
        e      = int'(ea) - int'(eb) + EXP_BIAS;
        if (!quo[QUO_W-1]) begin
            quo = quo << 1;
            e   = e - 1;
        end

        lost = 1'b0;
        if (e <= 0) begin
            sh = 1 - e;
            if (sh > QUO_W - 1) begin
                sh = QUO_W - 1;
            end
            lost = ((quo & ((64'd1 << sh) - 64'd1)) != 64'd0);
            quo  = quo >> sh;
            e    = 0;
        end
        r.exp  = exp_t'(e);
        r.mant = quo[QUO_W-1 -: MANT_W+1];
        r.grs  = {quo[2:1], quo[0] | lost | rem_nz};
        return r;
    endfunction

    task automatic check_flags(input int idx, input div_flags_t got, input div_flags_t want);
        if (got !== want) begin
            mismatches = mismatches + 1;
            $display("MISMATCH result_o.flags op %0d: got %h expected %h", idx, got, want);
        end
    endtask

    task automatic check_sign(input int idx, input logic got, input logic want);
        if (got !== want) begin
            mismatches = mismatches + 1;
            $display("MISMATCH result_o.sign op %0d: got %h expected %h", idx, got, want);
        end
    endtask

    task automatic check_exp(input int idx, input exp_t got, input exp_t want);
        if (got !== want) begin
            mismatches = mismatches + 1;
            $display("MISMATCH result_o.exp op %0d: got %h expected %h", idx, got, want);
        end
    endtask

    task automatic check_mant(input int idx, input mant_t got, input mant_t want);
        if (got !== want) begin
            mismatches = mismatches + 1;
            $display("MISMATCH result_o.mant op %0d: got %h expected %h", idx, got, want);
        end
    endtask

    task automatic check_grs(input int idx, input grs_t got, input grs_t want);
        if (got !== want) begin
            mismatches = mismatches + 1;
            $display("MISMATCH result_o.grs op %0d: got %h expected %h", idx, got, want);
        end
    endtask

    always @(posedge clk) begin : monitor
        div_result_t want;
        float_t      pa;
        float_t      pb;
        int          pc;
        int          errs_before;
        cycle = cycle + 1;
        if (reset_seen && out_valid) begin
            other_errors = other_errors + 1;
            $display("out_valid_o high in the cycle after a reset edge");
        end
        reset_seen = !rst_n;

        if (out_valid) begin
            if (pend_a.size() == 0) begin
                other_errors = other_errors + 1;
                $display("out_valid_o high with no operation in flight");
            end else begin
                pa = pend_a.pop_front();
                pb = pend_b.pop_front();
                pc = pend_cycle.pop_front();
                if (cycle - pc != LATENCY) begin
                    other_errors = other_errors + 1;
                    $display("op %0d arrived after %0d cycles instead of %0d",
                             checked, cycle - pc, LATENCY);
                end
                want        = model_divide(pa, pb);
                errs_before = mismatches;
                check_flags(checked, result.flags, want.flags);
                if (want.flags == '0) begin
                    check_sign(checked, result.sign, want.sign);
                    check_exp(checked, result.exp, want.exp);
                    check_mant(checked, result.mant, want.mant);
                    check_grs(checked, result.grs, want.grs);
                end
                if (mismatches != errs_before) begin
                    $display("  operands a %h b %h", pa, pb);
                end
                checked = checked + 1;
            end
        end

        if (rst_n && in_valid) begin
            pend_a.push_back(op_a);
            pend_b.push_back(op_b);
            pend_cycle.push_back(cycle);
        end
    end

    initial begin
        int waited;
        in_valid   = 1'b0;
        op_a       = '0;
        op_b       = '0;
        lfsr_state = LFSR_SEED;

        waited = 0;
        while (rst_n !== 1'b1 && waited < RESET_WAIT) begin
            @(posedge clk);
            waited = waited + 1;
        end
        if (rst_n !== 1'b1) begin
            timeouts = timeouts + 1;
            $display("timeout: reset was never released");
        end

        for (int n = 0; n < MAX_CYCLES && issued < NUM_OPS; n++) begin
            @(negedge clk);
            in_valid = (2'(draw_bits(2)) != 2'd0);
            op_a     = make_operand();
            op_b     = make_operand();
            if (in_valid) begin
                issued = issued + 1;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;

        waited = 0;
        while (pend_a.size() != 0 && waited < DRAIN_WAIT) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (pend_a.size() != 0) begin
            timeouts = timeouts + 1;
            $display("timeout: %0d results never came out", pend_a.size());
        end

        $display("checked %0d of %0d, mismatches %0d, other errors %0d, timeouts %0d",
                 checked, issued, mismatches, other_errors, timeouts);
        if (mismatches == 0 && other_errors == 0 && timeouts == 0 && checked == issued) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/fdiv_fmt_pkg.sv
rtl/fdiv_calc_pkg.sv
rtl/fdiv_seed.sv
rtl/fdiv_nr_stage.sv
rtl/fdiv_finish.sv
rtl/fdiv_top.sv
bench/fdiv_checker.sv
bench/tb_clock.sv
bench/fdiv_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile the divider testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module fdiv_tb \
    -Mdir obj_dir -o fdiv_sim || exit 1

out=$(./obj_dir/fdiv_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q '^Test passed$' && exit 0 || exit 1
